// ==== rtl/dt_defines.svh ====
`ifndef DT_DEFINES_SVH
`define DT_DEFINES_SVH

// ====================
// image geometry
// ====================

// side of the square image in pixels, power of two
`define DT_IMG_W 128

// packed rom word, msb is the leftmost pixel
`define DT_WORD_W 16

// word address into the packed rom
`define DT_STI_AW ($clog2(`DT_IMG_W * `DT_IMG_W / `DT_WORD_W))

// byte address into the result ram, one byte per pixel
`define DT_RES_AW ($clog2(`DT_IMG_W * `DT_IMG_W))

`define DT_DIST_W 8

`endif

// ==== rtl/dt_pkg.sv ====
`include "dt_defines.svh"

package dt_pkg;

    // pass sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_forward,
        st_backward,
        st_done
    } dt_state_t;

    // cycles within one pixel
    typedef enum logic [2:0] {
        ph_center,
        ph_nb0,
        ph_nb1,
        ph_nb2,
        ph_nb3,
        ph_write
    } dt_phase_t;

    typedef logic [`DT_STI_AW-1:0]       sti_addr_t;
    typedef logic [`DT_RES_AW-1:0]       res_addr_t;
    typedef logic [`DT_DIST_W-1:0]       dist_t;
    typedef logic [$clog2(`DT_IMG_W)-1:0] coord_t;

endpackage

// ==== rtl/dt_ctrl.sv ====
`include "dt_defines.svh"

module dt_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              pixel_last,
    output dt_pkg::dt_state_t state,
    output dt_pkg::coord_t    row,
    output dt_pkg::coord_t    col,
    output logic              pixel_start,
    output logic              done
);
    import dt_pkg::*;

    // interior limits, border row and column are skipped
    localparam coord_t FIRST = coord_t'(1);
    localparam coord_t LAST  = coord_t'(`DT_IMG_W - 2);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state       <= st_idle;
            row         <= FIRST;
            col         <= FIRST;
            pixel_start <= 1'b0;
        end
        else
        begin
            pixel_start <= 1'b0;
            case (state)
                st_idle:
                begin
                    state       <= st_forward;
                    pixel_start <= 1'b1;
                end
                st_forward:
                begin
                    if (pixel_last)
                    begin
                        // backward pass starts where forward ends
                        pixel_start <= 1'b1;
                        if (col != LAST)
                            col <= col + 1'b1;
                        else if (row != LAST)
                        begin
                            col <= FIRST;
                            row <= row + 1'b1;
                        end
                        else
                            state <= st_backward;
                    end
                end
                st_backward:
                begin
                    if (pixel_last)
                    begin
                        if (col != FIRST)
                        begin
                            col         <= col - 1'b1;
                            pixel_start <= 1'b1;
                        end
                        else if (row != FIRST)
                        begin
                            col         <= LAST;
                            row         <= row - 1'b1;
                            pixel_start <= 1'b1;
                        end
                        else
                            state <= st_done;
                    end
                end
                default:
                    state <= st_done;
            endcase
        end
    end

    assign done = (state == st_done);

endmodule

// ==== rtl/dt_pixel_seq.sv ====
module dt_pixel_seq (
    input  logic              clk,
    input  logic              reset,
    input  dt_pkg::dt_state_t state,
    input  logic              pixel_start,
    input  logic              object_bit,
    input  logic              center_zero,
    output dt_pkg::dt_phase_t phase,
    output logic              res_rd,
    output logic              res_wr,
    output logic              sti_rd,
    output logic              pixel_last
);
    import dt_pkg::*;

    logic      in_pixel;
    logic      active;
    logic      nb_phase;
    dt_phase_t next_phase;

    assign active   = pixel_start | in_pixel;
    assign nb_phase = (phase == ph_nb0) || (phase == ph_nb1) ||
                      (phase == ph_nb2) || (phase == ph_nb3);

    // ====================
    // strobes
    // ====================
    assign pixel_last = active && ((phase == ph_write) ||
                        (phase == ph_center && state == st_backward && center_zero));
    assign res_wr = active && (phase == ph_write);
    // forward centre comes from the rom, backward centre from the ram
    assign res_rd = active && (nb_phase || (phase == ph_center && state == st_backward));
    assign sti_rd = (state == st_forward);

    always_comb
    begin
        next_phase = ph_center;
        if (!pixel_last)
        begin
            case (phase)
                ph_center:
                begin
                    // background pixel goes straight to its write
                    if (state == st_forward && !object_bit)
                        next_phase = ph_write;
                    else
                        next_phase = ph_nb0;
                end
                ph_nb0:  next_phase = ph_nb1;
                ph_nb1:  next_phase = ph_nb2;
                ph_nb2:  next_phase = ph_nb3;
                ph_nb3:  next_phase = ph_write;
                default: next_phase = ph_center;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            phase    <= ph_center;
            in_pixel <= 1'b0;
        end
        else
        begin
            if (active)
                phase <= next_phase;
            if (pixel_last)
                in_pixel <= 1'b0;
            else if (pixel_start)
                in_pixel <= 1'b1;
        end
    end

endmodule

// ==== rtl/dt_addr_gen.sv ====
`include "dt_defines.svh"

module dt_addr_gen (
    input  dt_pkg::dt_state_t     state,
    input  dt_pkg::dt_phase_t     phase,
    input  dt_pkg::coord_t        row,
    input  dt_pkg::coord_t        col,
    input  logic [`DT_WORD_W-1:0] sti_di,
    output dt_pkg::sti_addr_t     sti_addr,
    output dt_pkg::res_addr_t     res_addr,
    output logic                  object_bit
);
    import dt_pkg::*;

    localparam int SEL_W = $clog2(`DT_WORD_W);

    res_addr_t        pix_idx;
    coord_t           nb_row;
    coord_t           nb_col;
    logic             nb_border;
    logic [SEL_W-1:0] bit_sel;

    // rom word holds WORD_W pixels of one row, leftmost in the msb
    assign pix_idx  = {row, col};
    assign sti_addr = pix_idx[`DT_RES_AW-1 -: `DT_STI_AW];
    assign bit_sel  = ~col[SEL_W-1:0];

    // ====================
    // neighbour offsets
    // ====================
    always_comb
    begin
        nb_row = row;
        nb_col = col;
        if (state == st_backward)
        begin
            // E, SW, S, SE
            case (phase)
                ph_nb0:
                    nb_col = col + 1'b1;
                ph_nb1:
                begin
                    nb_row = row + 1'b1;
                    nb_col = col - 1'b1;
                end
                ph_nb2:
                    nb_row = row + 1'b1;
                ph_nb3:
                begin
                    nb_row = row + 1'b1;
                    nb_col = col + 1'b1;
                end
                default:
                    nb_row = row;
            endcase
        end
        else
        begin
            // NW, N, NE, W
            case (phase)
                ph_nb0:
                begin
                    nb_row = row - 1'b1;
                    nb_col = col - 1'b1;
                end
                ph_nb1:
                    nb_row = row - 1'b1;
                ph_nb2:
                begin
                    nb_row = row - 1'b1;
                    nb_col = col + 1'b1;
                end
                ph_nb3:
                    nb_col = col - 1'b1;
                default:
                    nb_row = row;
            endcase
        end
    end

    assign nb_border = (nb_row == '0) || (&nb_row) || (nb_col == '0) || (&nb_col);
    assign res_addr  = {nb_row, nb_col};

    // in neighbour phases a border neighbour reads as background
    assign object_bit = (phase == ph_center || phase == ph_write) ? sti_di[bit_sel]
                                                                  : !nb_border;

endmodule

// ==== rtl/dt_min_acc.sv ====
module dt_min_acc (
    input  logic              clk,
    input  logic              reset,
    input  dt_pkg::dt_state_t state,
    input  dt_pkg::dt_phase_t phase,
    input  logic              object_bit,
    input  dt_pkg::dist_t     res_di,
    output dt_pkg::dist_t     res_do,
    output logic              center_zero
);
    import dt_pkg::*;

    dist_t acc;
    dist_t nb_val;
    dist_t step;
    logic  nb_phase;

    assign nb_phase = (phase == ph_nb0) || (phase == ph_nb1) ||
                      (phase == ph_nb2) || (phase == ph_nb3);

    // border neighbours count as zero
    assign nb_val = object_bit ? res_di : '0;
    assign step   = (state == st_backward) ? dist_t'(nb_val + 1'b1) : nb_val;

    assign center_zero = (state == st_backward) && (phase == ph_center) && (res_di == '0);

    // ====================
    // running minimum
    // ====================
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            acc <= '1;
        else if (phase == ph_center)
        begin
            if (state == st_backward)
                acc <= res_di;
            else
                acc <= '1;
        end
        else if (nb_phase && (step < acc))
            acc <= step;
    end

    always_comb
    begin
        if (state == st_forward)
            res_do = object_bit ? dist_t'(acc + 1'b1) : '0;
        else
            res_do = acc;
    end

endmodule

// ==== rtl/dt_top.sv ====
`include "dt_defines.svh"

module dt_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`DT_WORD_W-1:0] sti_di,
    input  dt_pkg::dist_t         res_di,
    output logic                  sti_rd,
    output logic                  res_rd,
    output logic                  res_wr,
    output logic                  done,
    output dt_pkg::sti_addr_t     sti_addr,
    output dt_pkg::res_addr_t     res_addr,
    output dt_pkg::dist_t         res_do
);

    dt_pkg::dt_state_t state;
    dt_pkg::dt_phase_t phase;
    dt_pkg::coord_t    row;
    dt_pkg::coord_t    col;
    logic              pixel_start;
    logic              pixel_last;
    logic              object_bit;
    logic              center_zero;

    dt_ctrl i_ctrl (
        .clk         (clk),
        .reset       (reset),
        .pixel_last  (pixel_last),
        .state       (state),
        .row         (row),
        .col         (col),
        .pixel_start (pixel_start),
        .done        (done)
    );

    dt_pixel_seq i_pixel_seq (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .pixel_start (pixel_start),
        .object_bit  (object_bit),
        .center_zero (center_zero),
        .phase       (phase),
        .res_rd      (res_rd),
        .res_wr      (res_wr),
        .sti_rd      (sti_rd),
        .pixel_last  (pixel_last)
    );

    dt_addr_gen i_addr_gen (
        .state      (state),
        .phase      (phase),
        .row        (row),
        .col        (col),
        .sti_di     (sti_di),
        .sti_addr   (sti_addr),
        .res_addr   (res_addr),
        .object_bit (object_bit)
    );

    dt_min_acc i_min_acc (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .phase       (phase),
        .object_bit  (object_bit),
        .res_di      (res_di),
        .res_do      (res_do),
        .center_zero (center_zero)
    );

endmodule

// ==== test/dt_checker.sv ====
module dt_checker (
    input logic clk,
    input logic reset,
    input logic res_rd,
    input logic res_wr,
    input logic sti_rd,
    input logic done
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // one ram port, so never read and write together
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!reset) !(res_rd && res_wr))
    else
    begin
        $error("res_rd and res_wr high in the same cycle");
        fail_count++;
    end

    a_done_sticky: assert property (@(posedge clk) disable iff (!reset) done |=> done)
    else
    begin
        $error("done fell without a reset");
        fail_count++;
    end

    a_no_wr_done: assert property (@(posedge clk) disable iff (!reset) done |-> !res_wr)
    else
    begin
        $error("ram write while done is high");
        fail_count++;
    end

    a_no_sti_done: assert property (@(posedge clk) disable iff (!reset) done |-> !sti_rd)
    else
    begin
        $error("rom read while done is high");
        fail_count++;
    end

endmodule

// ==== test/dt_tb.sv ====
`include "dt_defines.svh"

module dt_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import dt_pkg::*;

    localparam int    IMG_W     = `DT_IMG_W;
    localparam int    WORD_W    = `DT_WORD_W;
    localparam int    ROM_DEPTH = 2 ** `DT_STI_AW;
    localparam int    RAM_DEPTH = 2 ** `DT_RES_AW;
    localparam int    N_TESTS   = 5;
    localparam int    TIMEOUT   = N_TESTS * IMG_W * IMG_W * 12;
    localparam dist_t SENTINEL  = 8'hee;

    logic                  clk;
    logic                  reset;
    logic [`DT_WORD_W-1:0] sti_di;
    dist_t                 res_di;
    logic                  sti_rd;
    logic                  res_rd;
    logic                  res_wr;
    logic                  done;
    sti_addr_t             sti_addr;
    res_addr_t             res_addr;
    dist_t                 res_do;

    logic [`DT_WORD_W-1:0] rom [0:ROM_DEPTH-1];
    dist_t                 ram [0:RAM_DEPTH-1];
    logic                  preset_ram;
    logic                  img [0:IMG_W-1][0:IMG_W-1];
    int                    ref_dist [0:IMG_W-1][0:IMG_W-1];
    int                    errors;
    int                    tests_passed;
    int                    tests_failed;
    int                    cycle_count;

    dt_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .sti_di   (sti_di),
        .res_di   (res_di),
        .sti_rd   (sti_rd),
        .res_rd   (res_rd),
        .res_wr   (res_wr),
        .done     (done),
        .sti_addr (sti_addr),
        .res_addr (res_addr),
        .res_do   (res_do)
    );

    bind dt_top dt_checker i_checker (
        .clk    (clk),
        .reset  (reset),
        .res_rd (res_rd),
        .res_wr (res_wr),
        .sti_rd (sti_rd),
        .done   (done)
    );

    // ====================
    // memory models
    // ====================
    // read data only while the matching strobe is high
    assign sti_di = sti_rd ? rom[sti_addr] : '0;
    assign res_di = res_rd ? ram[res_addr] : '0;

    always @(posedge clk)
    begin
        if (preset_ram)
        begin
            for (int a = 0; a < RAM_DEPTH; a++)
                ram[res_addr_t'(a)] <= SENTINEL;
        end
        else if (res_wr)
            ram[res_addr] <= res_do;
    end

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ====================
    // helpers
    // ====================
    function automatic res_addr_t addr_of(input int r, input int c);
        return res_addr_t'(r * IMG_W + c);
    endfunction

    function automatic int min4(input int a, input int b, input int c, input int d);
        int m;
        m = a;
        if (b < m)
            m = b;
        if (c < m)
            m = c;
        if (d < m)
            m = d;
        return m;
    endfunction

    task automatic check_dist(input string name, input res_addr_t addr,
                              input dist_t exp, input dist_t act);
        if (act !== exp)
        begin
            $display("MISMATCH %s addr %0d: expected %0d actual %0d", name, addr, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("MISMATCH %s %s: expected %b actual %b", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic clear_image();
        for (int r = 0; r < IMG_W; r++)
            for (int c = 0; c < IMG_W; c++)
            begin
                img[r][c]      = 1'b0;
                ref_dist[r][c] = 0;
            end
    endtask

    // leftmost pixel of each word in the msb
    task automatic pack_rom();
        logic [`DT_WORD_W-1:0] word;
        for (int r = 0; r < IMG_W; r++)
            for (int wc = 0; wc < IMG_W / WORD_W; wc++)
            begin
                word = '0;
                for (int k = 0; k < WORD_W; k++)
                    word = {word[WORD_W-2:0], img[r][wc * WORD_W + k]};
                rom[sti_addr_t'(r * (IMG_W / WORD_W) + wc)] = word;
            end
    endtask

    // chessboard transform, zero border
    task automatic build_reference();
        int m;
        for (int r = 1; r < IMG_W - 1; r++)
            for (int c = 1; c < IMG_W - 1; c++)
            begin
                m = min4(ref_dist[r-1][c-1], ref_dist[r-1][c], ref_dist[r-1][c+1],
                         ref_dist[r][c-1]);
                ref_dist[r][c] = img[r][c] ? m + 1 : 0;
            end
        for (int r = IMG_W - 2; r >= 1; r--)
            for (int c = IMG_W - 2; c >= 1; c--)
            begin
                m = min4(ref_dist[r][c+1], ref_dist[r+1][c-1], ref_dist[r+1][c],
                         ref_dist[r+1][c+1]) + 1;
                if (ref_dist[r][c] != 0 && m < ref_dist[r][c])
                    ref_dist[r][c] = m;
            end
    endtask

    task automatic start_run();
        @(posedge clk);
        #1;
        reset      = 1'b0;
        preset_ram = 1'b1;
        pack_rom();
        @(posedge clk);
        #1;
        preset_ram = 1'b0;
        @(posedge clk);
        #1;
        reset = 1'b1;
    endtask

    task automatic run_engine(input string name);
        start_run();
        @(negedge clk);
        check_flag(name, "done after reset", 1'b0, done);
        check_flag(name, "res_wr after reset", 1'b0, res_wr);
        check_flag(name, "res_rd after reset", 1'b0, res_rd);
        while (done !== 1'b1)
            @(negedge clk);
        repeat (20)
        begin
            @(negedge clk);
            check_flag(name, "done held", 1'b1, done);
            check_flag(name, "res_wr after done", 1'b0, res_wr);
        end
        // border bytes are never written
        for (int r = 0; r < IMG_W; r++)
            for (int c = 0; c < IMG_W; c++)
                if (r == 0 || c == 0 || r == IMG_W - 1 || c == IMG_W - 1)
                    check_dist(name, addr_of(r, c), SENTINEL, ram[addr_of(r, c)]);
    endtask

    task automatic compare_interior(input string name);
        for (int r = 1; r < IMG_W - 1; r++)
            for (int c = 1; c < IMG_W - 1; c++)
                check_dist(name, addr_of(r, c), dist_t'(ref_dist[r][c]), ram[addr_of(r, c)]);
    endtask

    task automatic finish_test(input string name);
        if (errors == 0)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors);
        end
        errors = 0;
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_blank();
        clear_image();
        run_engine("blank");
        compare_interior("blank");
        finish_test("blank");
    endtask

    task automatic test_single_pixel();
        clear_image();
        img[37][90]      = 1'b1;
        ref_dist[37][90] = 1;
        run_engine("single_pixel");
        compare_interior("single_pixel");
        finish_test("single_pixel");
    endtask

    task automatic test_square();
        clear_image();
        for (int r = 20; r <= 28; r++)
            for (int c = 30; c <= 38; c++)
                img[r][c] = 1'b1;
        build_reference();
        run_engine("square");
        compare_interior("square");
        // five rings in a 9 by 9 square
        check_dist("square", addr_of(24, 34), 8'd5, ram[addr_of(24, 34)]);
        finish_test("square");
    endtask

    task automatic test_random();
        clear_image();
        for (int r = 0; r < IMG_W; r++)
            for (int c = 0; c < IMG_W; c++)
                img[r][c] = ($urandom_range(99, 0) < 70);
        build_reference();
        run_engine("random");
        compare_interior("random");
        finish_test("random");
    endtask

    task automatic test_full_image();
        clear_image();
        for (int r = 0; r < IMG_W; r++)
            for (int c = 0; c < IMG_W; c++)
                img[r][c] = 1'b1;
        build_reference();
        run_engine("full_image");
        compare_interior("full_image");
        finish_test("full_image");
    endtask

    initial
    begin
        void'($urandom(32'h874f));
        reset        = 1'b0;
        preset_ram   = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int a = 0; a < ROM_DEPTH; a++)
            rom[sti_addr_t'(a)] = '0;
        clear_image();

        test_blank();
        test_single_pixel();
        test_square();
        test_random();
        test_full_image();

        $display("summary: %0d tests passed, %0d failed, %0d assertion failures",
                 tests_passed, tests_failed, i_dut.i_checker.fail_count);
        if (tests_failed == 0 && i_dut.i_checker.fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/dt_pkg.sv
rtl/dt_ctrl.sv
rtl/dt_pixel_seq.sv
rtl/dt_addr_gen.sv
rtl/dt_min_acc.sv
rtl/dt_top.sv
test/dt_checker.sv
test/dt_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = dt_tb
FILELIST = sim.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD)
